// ==== Makefile ====
TOP = vtMux_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f vtMux.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== logic/byteRouter.sv ====
`timescale 1ns/1ps
`include "vt_macros.svh"

module byteRouter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 inReq,
	input  vtPkg::laneId_t       inLane,
	input  vtPkg::byte_t         inByte,
	output logic                 inAck,
	input  logic [`VT_LANES-1:0] slotBusy,
	output logic [`VT_LANES-1:0] byteValid,
	output vtPkg::byte_t         byteOut
);

	typedef enum logic [1:0] {
		IDLE,
		DELIVER,
		WAITLOW
	} routeState_t;

	routeState_t state;
	logic        accept;

	// new request for a lane whose command slot is empty
	assign accept = (state == IDLE) && inReq && !slotBusy[inLane];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= IDLE;
			byteValid <= '0;
			inAck     <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (accept)
					begin
						byteValid[inLane] <= 1'b1;   // single-cycle pulse
						state             <= DELIVER;
					end
				DELIVER:
				begin
					byteValid <= '0;
					inAck     <= 1'b1;               // byte is with the parser now
					state     <= WAITLOW;
				end
				WAITLOW:
					if (!inReq)
					begin
						inAck <= 1'b0;
						state <= IDLE;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			byteOut <= inByte;   // shared by all lanes
	end

endmodule

// ==== logic/commandArbiter.sv ====
`timescale 1ns/1ps
`include "vt_macros.svh"

module commandArbiter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [`VT_LANES-1:0] cmdStrobe,
	input  vtPkg::cmd_t          cmd [`VT_LANES],
	input  vtPkg::paramVal_t     pn1 [`VT_LANES],
	input  vtPkg::paramVal_t     pn2 [`VT_LANES],
	input  vtPkg::paramVal_t     pns [`VT_LANES],
	output logic [`VT_LANES-1:0] slotBusy,
	output logic                 outReq,
	input  logic                 outAck,
	output vtPkg::laneId_t       outLane,
	output vtPkg::cmd_t          outCmd,
	output vtPkg::paramVal_t     outPn1,
	output vtPkg::paramVal_t     outPn2,
	output vtPkg::paramVal_t     outPns
);

	import vtPkg::*;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		RELEASE
	} outState_t;

	outState_t oState;
	laneId_t   lastLane;        // lane served most recently
	laneId_t   pickLane;
	logic      pickValid;
	logic      launch;
	logic      freeSlot;
	cmd_t      slotCmd [`VT_LANES];
	paramVal_t slotPn1 [`VT_LANES];
	paramVal_t slotPn2 [`VT_LANES];
	paramVal_t slotPns [`VT_LANES];

	assign launch   = (oState == IDLE) && pickValid;
	assign freeSlot = (oState == REQ) && outAck;

	// first busy slot after lastLane
	always_comb
	begin
		pickValid = 1'b0;
		pickLane  = lastLane;
		for (int k = 1; k <= `VT_LANES; k++)
		begin
			if (!pickValid && slotBusy[(int'(lastLane) + k) % `VT_LANES])
			begin
				pickValid = 1'b1;
				pickLane  = laneId_t'((int'(lastLane) + k) % `VT_LANES);
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			slotBusy <= '0;
		else
		begin
			if (freeSlot)
				slotBusy[outLane] <= 1'b0;
			for (int i = 0; i < `VT_LANES; i++)
			begin
				if (cmdStrobe[i])
					slotBusy[i] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `VT_LANES; i++)
		begin
			if (cmdStrobe[i])
			begin
				slotCmd[i] <= cmd[i];
				slotPn1[i] <= pn1[i];
				slotPn2[i] <= pn2[i];
				slotPns[i] <= pns[i];
			end
		end
	end

	// four-phase master
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			oState   <= IDLE;
			outReq   <= 1'b0;
			lastLane <= laneId_t'(`VT_LANES - 1);   // lane 0 goes first
		end
		else
		begin
			case (oState)
				IDLE:
					if (launch)
					begin
						outReq <= 1'b1;
						oState <= REQ;
					end
				REQ:
					if (outAck)
					begin
						outReq   <= 1'b0;
						lastLane <= outLane;
						oState   <= RELEASE;
					end
				RELEASE:
					if (!outAck)
						oState <= IDLE;
				default:
					oState <= IDLE;
			endcase
		end
	end

	// fields stay put for the whole transfer
	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			outLane <= pickLane;
			outCmd  <= slotCmd[pickLane];
			outPn1  <= slotPn1[pickLane];
			outPn2  <= slotPn2[pickLane];
			outPns  <= slotPns[pickLane];
		end
	end

endmodule

// ==== logic/escParser.sv ====
`timescale 1ns/1ps
`include "vt_macros.svh"

module escParser (
	input  logic             clk,
	input  logic             rst,
	input  logic             byteValid,
	input  vtPkg::byte_t     data,
	output logic             cmdStrobe,
	output vtPkg::cmd_t      cmd,
	output vtPkg::paramVal_t pn1,
	output vtPkg::paramVal_t pn2,
	output vtPkg::paramVal_t pns
);

	import vtPkg::*;

	parseState_t state;
	paramVal_t   acc1;      // running parameters
	paramVal_t   acc2;
	paramVal_t   accS;
	paramVal_t   nextP1;
	paramVal_t   nextP2;
	paramVal_t   nextPs;
	paramVal_t   digit;
	cmd_t        nextCmd;
	logic        fire;
	logic        isDigit;

	assign isDigit = (data >= 8'h30) && (data <= 8'h39);
	assign digit   = data - 8'h30;

	// state transitions, one per delivered byte
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= START;
		else if (byteValid)
		begin
			case (state)
				START:
					state <= (data == `VT_ESC) ? ESC : START;
				ESC:
					case (data)
						8'h5b:   state <= CSI;         // [
						8'h28:   state <= LBRACKET;    // (
						8'h29:   state <= RBRACKET;    // )
						8'h23:   state <= SHARP;       // #
						default: state <= START;
					endcase
				CSI:
					if (isDigit)
						state <= PN1;
					else if (data == 8'h3f)            // ?
						state <= QUES;
					else
						state <= START;
				DEL1:
					state <= isDigit ? PN2 : START;
				DEL2:
					state <= isDigit ? PNS : START;
				PN1:
					if (isDigit)
						state <= PN1;
					else if (data == 8'h3b)
						state <= DEL1;
					else
						state <= START;
				PN2:
					if (isDigit)
						state <= PN2;
					else if (data == 8'h3b)
						state <= DEL2;
					else
						state <= START;
				PNS:
					if (isDigit)
						state <= PNS;
					else if (data == 8'h3b)
						state <= DEL2;
					else
						state <= START;
				QUES:
					state <= isDigit ? QPN1 : START;
				QPN1:
					state <= isDigit ? QPN1 : START;
				default:
					state <= START;      // SHARP and charset selects end here
			endcase
		end
	end

	// command decode and parameter update for the current byte
	always_comb
	begin
		fire    = 1'b0;
		nextCmd = INPUT;
		nextP1  = acc1;
		nextP2  = acc2;
		nextPs  = accS;
		case (state)
			START:
				if (data != `VT_ESC)
				begin
					fire   = 1'b1;
					nextP1 = data;         // plain character
				end
			ESC:
			begin
				fire = 1'b1;
				case (data)
					8'h44:   nextCmd = IND;     // D
					8'h45:   nextCmd = NEL;     // E
					8'h4d:   nextCmd = RI;      // M
					8'h37:   nextCmd = DECSC;   // 7
					8'h38:   nextCmd = DECRC;   // 8
					8'h4e:   nextCmd = SS2;     // N
					8'h30:   nextCmd = SS3;     // 0
					default: fire = 1'b0;
				endcase
			end
			CSI:
			begin
				fire = 1'b1;
				if (isDigit)
				begin
					nextCmd = LOAD_SGR;
					nextP1  = digit;
				end
				else
				begin
					case (data)
						8'h48, 8'h66:              // H, f
						begin
							nextCmd = CUP;
							nextP1  = 8'd1;
							nextP2  = 8'd1;
						end
						8'h72:                     // r
						begin
							nextCmd = DECSTBM;
							nextP1  = 8'd1;
							nextP2  = paramVal_t'(`CONSOLE_LINES);
						end
						8'h4a:                     // J
						begin
							nextCmd = ED;
							nextP1  = 8'd0;
						end
						8'h4b:                     // K
						begin
							nextCmd = EL;
							nextP1  = 8'd0;
						end
						8'h6d:   nextCmd = SGR0;   // m
						default: fire = 1'b0;
					endcase
				end
			end
			DEL1:
				if (isDigit)
					nextP2 = digit;
			DEL2:
				if (isDigit)
					nextPs = digit;
			QUES:
				if (isDigit)
					nextP1 = digit;
			PN1:
				if (isDigit)
					nextP1 = acc1 * 8'd10 + digit;
				else
				begin
					fire = 1'b1;
					case (data)
						8'h41:   nextCmd = CUU;
						8'h42:   nextCmd = CUD;
						8'h43:   nextCmd = CUF;
						8'h44:   nextCmd = CUB;
						8'h4a:   nextCmd = ED;
						8'h4b:   nextCmd = EL;
						8'h50:   nextCmd = DCH;
						8'h4c:   nextCmd = IL;
						8'h4d:   nextCmd = DL;
						8'h6d:   nextCmd = SGR;
						8'h3b:
						begin
							nextCmd = EMIT_SGR;
							nextPs  = acc1;
						end
						default: fire = 1'b0;
					endcase
				end
			PN2:
				if (isDigit)
					nextP2 = acc2 * 8'd10 + digit;
				else
				begin
					fire = 1'b1;
					case (data)
						8'h48, 8'h66: nextCmd = CUP;
						8'h72:        nextCmd = DECSTBM;
						8'h6d:        nextCmd = SGR;
						8'h3b:
						begin
							nextCmd = EMIT_SGR;
							nextPs  = acc2;
						end
						default:      fire = 1'b0;
					endcase
				end
			PNS:
				if (isDigit)
					nextPs = accS * 8'd10 + digit;
				else
				begin
					fire = 1'b1;
					case (data)
						8'h3b:   nextCmd = EMIT_SGR;
						8'h6d:   nextCmd = SGR;
						default: fire = 1'b0;
					endcase
				end
			QPN1:
				if (isDigit)
					nextP1 = acc1 * 8'd10 + digit;
				else
				begin
					fire = 1'b1;
					case (data)
						8'h68:   nextCmd = SETMODE;     // h
						8'h6c:   nextCmd = RESETMODE;   // l
						default: fire = 1'b0;
					endcase
				end
			LBRACKET, RBRACKET:
				case (data)
					8'h41, 8'h42, 8'h30, 8'h31, 8'h32:
					begin
						fire    = 1'b1;
						nextCmd = (state == LBRACKET) ? SCS0 : SCS1;
						nextP1  = data;            // charset designator
					end
					default: fire = 1'b0;
				endcase
			default:
				fire = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			cmdStrobe <= 1'b0;
		else
			cmdStrobe <= byteValid && fire;
	end

	// outputs only move on a strobe
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			acc1 <= '0;
			acc2 <= '0;
			accS <= '0;
			cmd  <= INPUT;
			pn1  <= '0;
			pn2  <= '0;
			pns  <= '0;
		end
		else if (byteValid)
		begin
			acc1 <= nextP1;
			acc2 <= nextP2;
			accS <= nextPs;
			if (fire)
			begin
				cmd <= nextCmd;
				pn1 <= nextP1;
				pn2 <= nextP2;
				pns <= nextPs;
			end
		end
	end

endmodule

// ==== logic/vtMux.sv ====
`timescale 1ns/1ps
`include "vt_macros.svh"

module vtMux (
	input  logic             clk,
	input  logic             rst,
	input  logic             inReq,
	input  vtPkg::laneId_t   inLane,
	input  vtPkg::byte_t     inByte,
	output logic             inAck,
	output logic             outReq,
	input  logic             outAck,
	output vtPkg::laneId_t   outLane,
	output vtPkg::cmd_t      outCmd,
	output vtPkg::paramVal_t outPn1,
	output vtPkg::paramVal_t outPn2,
	output vtPkg::paramVal_t outPns
);

	import vtPkg::*;

	logic [`VT_LANES-1:0] byteValid;
	logic [`VT_LANES-1:0] slotBusy;
	logic [`VT_LANES-1:0] cmdStrobe;
	byte_t                byteOut;
	cmd_t                 laneCmd [`VT_LANES];
	paramVal_t            lanePn1 [`VT_LANES];
	paramVal_t            lanePn2 [`VT_LANES];
	paramVal_t            lanePns [`VT_LANES];

	byteRouter router (
		.clk(clk),
		.rst(rst),
		.inReq(inReq),
		.inLane(inLane),
		.inByte(inByte),
		.inAck(inAck),
		.slotBusy(slotBusy),
		.byteValid(byteValid),
		.byteOut(byteOut)
	);

	// one parser per session
	for (genvar g = 0; g < `VT_LANES; g++)
	begin : genLane
		escParser parser (
			.clk(clk),
			.rst(rst),
			.byteValid(byteValid[g]),
			.data(byteOut),
			.cmdStrobe(cmdStrobe[g]),
			.cmd(laneCmd[g]),
			.pn1(lanePn1[g]),
			.pn2(lanePn2[g]),
			.pns(lanePns[g])
		);
	end

	commandArbiter arbiter (
		.clk(clk),
		.rst(rst),
		.cmdStrobe(cmdStrobe),
		.cmd(laneCmd),
		.pn1(lanePn1),
		.pn2(lanePn2),
		.pns(lanePns),
		.slotBusy(slotBusy),
		.outReq(outReq),
		.outAck(outAck),
		.outLane(outLane),
		.outCmd(outCmd),
		.outPn1(outPn1),
		.outPn2(outPn2),
		.outPns(outPns)
	);

endmodule

// ==== logic/vtPkg.sv ====
`include "vt_macros.svh"

package vtPkg;

	typedef logic [7:0] byte_t;                      // raw host character
	typedef logic [`VT_LANE_BITS-1:0] laneId_t;      // session number
	typedef logic [7:0] paramVal_t;                  // numeric parameter, wraps mod 256

	// decoded commands
	typedef enum logic [4:0] {
		INPUT,       // printable char in pn1
		IND,
		NEL,
		RI,
		DECSC,
		DECRC,
		SS2,
		SS3,
		LOAD_SGR,    // first digit after CSI
		CUP,
		DECSTBM,
		ED,
		EL,
		SGR0,
		CUU,
		CUD,
		CUF,
		CUB,
		DCH,
		IL,
		DL,
		SGR,
		EMIT_SGR,    // parameter closed by ';'
		SETMODE,
		RESETMODE,
		SCS0,        // G0 charset select
		SCS1         // G1 charset select
	} cmd_t;

	// escape DFA states
	typedef enum logic [3:0] {
		START,
		ESC,
		CSI,
		DEL1,
		DEL2,
		PN1,
		PN2,
		PNS,
		QUES,
		QPN1,
		SHARP,
		LBRACKET,
		RBRACKET
	} parseState_t;

endpackage

// ==== logic/vt_macros.svh ====
`ifndef VT_MACROS_SVH
`define VT_MACROS_SVH

// number of independent sessions, one parser each
`define VT_LANES 4

// bits needed to name a lane
`define VT_LANE_BITS 2

// screen height, default bottom margin for DECSTBM
`define CONSOLE_LINES 24

// escape introducer
`define VT_ESC 8'h1b

`endif

// ==== sim/vtMux_assert.sv ====
`timescale 1ns/1ps

module vtMux_assert (
	input logic             clk,
	input logic             rst,
	input logic             inReq,
	input logic             inAck,
	input logic             outReq,
	input logic             outAck,
	input vtPkg::laneId_t   outLane,
	input vtPkg::cmd_t      outCmd,
	input vtPkg::paramVal_t outPn1,
	input vtPkg::paramVal_t outPn2,
	input vtPkg::paramVal_t outPns
);

	int failCount = 0;   // assertion failures so far

	inReqHeld: assert property (@(posedge clk) disable iff (rst) inReq && !inAck |=> inReq)
		else begin $error("inReq dropped before inAck"); failCount++; end

	inAckNeedsReq: assert property (@(posedge clk) disable iff (rst) $rose(inAck) |-> inReq)
		else begin $error("inAck rose without inReq"); failCount++; end

	// router keeps the ack until the host lets go
	inAckHeld: assert property (@(posedge clk) disable iff (rst) inAck && inReq |=> inAck)
		else begin $error("inAck dropped while inReq high"); failCount++; end

	outReqHeld: assert property (@(posedge clk) disable iff (rst) outReq && !outAck |=> outReq)
		else begin $error("outReq dropped before outAck"); failCount++; end

	outAckNeedsReq: assert property (@(posedge clk) disable iff (rst) $rose(outAck) |-> outReq)
		else begin $error("outAck rose without outReq"); failCount++; end

	outFieldsStable: assert property (@(posedge clk) disable iff (rst)
		outReq |=> !outReq || $stable({outLane, outCmd, outPn1, outPn2, outPns}))
		else begin $error("command fields moved while outReq high"); failCount++; end

	// both handshakes quiet once reset is released
	idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> !inAck && !outReq)
		else begin $error("inAck or outReq high after reset"); failCount++; end

endmodule

bind vtMux vtMux_assert protocolChecks (
	.clk(clk),
	.rst(rst),
	.inReq(inReq),
	.inAck(inAck),
	.outReq(outReq),
	.outAck(outAck),
	.outLane(outLane),
	.outCmd(outCmd),
	.outPn1(outPn1),
	.outPn2(outPn2),
	.outPns(outPns)
);

// ==== sim/vtMux_tb.sv ====
`timescale 1ns/1ps
`include "vt_macros.svh"

module vtMux_tb;

	import vtPkg::*;

	typedef struct packed {
		laneId_t    lane;
		cmd_t       cmd;
		paramVal_t  p1;
		paramVal_t  p2;
		paramVal_t  ps;
		logic [2:0] mask;   // which of p1, p2, ps are compared
	} expect_t;

	localparam logic [2:0] P1 = 3'b001;
	localparam logic [2:0] P2 = 3'b010;
	localparam logic [2:0] PS = 3'b100;
	// about 70 bytes at up to 25 cycles each, plus the 200-cycle hold, doubled
	localparam int MAX_CYCLES = 4000;

	logic      clk;
	logic      rst;
	logic      inReq;
	laneId_t   inLane;
	byte_t     inByte;
	logic      inAck;
	logic      outReq;
	logic      outAck;
	laneId_t   outLane;
	cmd_t      outCmd;
	paramVal_t outPn1;
	paramVal_t outPn2;
	paramVal_t outPns;

	expect_t   expQ[$];          // pending commands, all lanes
	int        cycles = 0;
	int        holdUntil = 0;    // consumer withholds outAck before this cycle
	logic      reqSeen = 1'b0;

	vtMux uut (
		.clk(clk),
		.rst(rst),
		.inReq(inReq),
		.inLane(inLane),
		.inByte(inByte),
		.inAck(inAck),
		.outReq(outReq),
		.outAck(outAck),
		.outLane(outLane),
		.outCmd(outCmd),
		.outPn1(outPn1),
		.outPn2(outPn2),
		.outPns(outPns)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reportMismatch(input string name, input int got, input int want);
		abortRun($sformatf("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, want));
	endtask

	task automatic expectCmd(input int lane, input cmd_t c, input int a, input int b,
			input int s, input logic [2:0] mask);
		expect_t e;
		e.lane = laneId_t'(lane);
		e.cmd  = c;
		e.p1   = paramVal_t'(a);
		e.p2   = paramVal_t'(b);
		e.ps   = paramVal_t'(s);
		e.mask = mask;
		expQ.push_back(e);
	endtask

	// one four-phase host transfer
	task automatic sendByte(input int lane, input byte_t b);
		@(posedge clk);
		inReq  <= 1'b1;
		inLane <= laneId_t'(lane);
		inByte <= b;
		do @(posedge clk); while (!inAck);
		inReq <= 1'b0;
		do @(posedge clk); while (inAck);
	endtask

	task automatic sendText(input int lane, input string s);
		for (int i = 0; i < s.len(); i++)
			sendByte(lane, s.getc(i));
	endtask

	// plain characters each come back as INPUT
	task automatic sendPlain(input int lane, input string s);
		for (int i = 0; i < s.len(); i++)
			expectCmd(lane, INPUT, s.getc(i), 0, 0, P1);
		sendText(lane, s);
	endtask

	task automatic drain();
		while (expQ.size() != 0)
			@(posedge clk);
	endtask

	// byte-by-byte random mix of four sessions
	task automatic runInterleaved();
		string seq [`VT_LANES];
		int    pos [`VT_LANES];
		int    left;
		int    lane;
		seq[0] = "ab\033[2J";
		seq[1] = "\033[7;9H";
		seq[2] = "\033[?7lz";
		seq[3] = "\033Mx\033)0";
		expectCmd(0, INPUT, 8'h61, 0, 0, P1);
		expectCmd(0, INPUT, 8'h62, 0, 0, P1);
		expectCmd(0, LOAD_SGR, 2, 0, 0, P1);
		expectCmd(0, ED, 2, 0, 0, P1);
		expectCmd(1, LOAD_SGR, 7, 0, 0, P1);
		expectCmd(1, EMIT_SGR, 7, 0, 7, P1 | PS);
		expectCmd(1, CUP, 7, 9, 0, P1 | P2);
		expectCmd(2, RESETMODE, 7, 0, 0, P1);
		expectCmd(2, INPUT, 8'h7a, 0, 0, P1);
		expectCmd(3, RI, 0, 0, 0, 3'b000);
		expectCmd(3, INPUT, 8'h78, 0, 0, P1);
		expectCmd(3, SCS1, 8'h30, 0, 0, P1);
		left = 0;
		for (int i = 0; i < `VT_LANES; i++)
		begin
			pos[i] = 0;
			left += seq[i].len();
		end
		while (left > 0)
		begin
			lane = $urandom_range(`VT_LANES - 1, 0);
			if (pos[lane] < seq[lane].len())
			begin
				sendByte(lane, seq[lane].getc(pos[lane]));
				pos[lane]++;
				left--;
			end
		end
	endtask

	// command port consumer with random ack delay
	task automatic serveCommands();
		int delay;
		forever
		begin
			@(posedge clk);
			if (outReq && !outAck && cycles >= holdUntil)
			begin
				delay = $urandom_range(5, 0);
				repeat (delay) @(posedge clk);
				outAck <= 1'b1;
				while (outReq)
					@(posedge clk);
				outAck <= 1'b0;
			end
		end
	endtask

	initial
	begin
		serveCommands();
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			abortRun($sformatf("timeout: run passed %0d cycles", MAX_CYCLES));
		else if (uut.protocolChecks.failCount != 0)
			abortRun("a handshake assertion on the host or command port failed");
	end

	// compare each new command with the oldest one expected on its lane
	always @(posedge clk)
	begin : outputCheck
		int      idx;
		expect_t e;
		idx = -1;
		if (!rst && outReq && !reqSeen)
		begin
			for (int i = 0; i < expQ.size(); i++)
				if (idx < 0 && expQ[i].lane == outLane)
					idx = i;
			assert (idx >= 0)
				else abortRun($sformatf("command %0d on lane %0d was not expected", outCmd, outLane));
			if (idx >= 0)
			begin
				e = expQ[idx];
				assert (outCmd == e.cmd) else reportMismatch("outCmd", outCmd, e.cmd);
				assert (!e.mask[0] || outPn1 == e.p1) else reportMismatch("outPn1", outPn1, e.p1);
				assert (!e.mask[1] || outPn2 == e.p2) else reportMismatch("outPn2", outPn2, e.p2);
				assert (!e.mask[2] || outPns == e.ps) else reportMismatch("outPns", outPns, e.ps);
				expQ.delete(idx);
			end
		end
		reqSeen = outReq;
	end

	initial
	begin
		int start;
		void'($urandom(73679));
		rst    = 1'b1;
		inReq  = 1'b0;
		inLane = '0;
		inByte = '0;
		outAck = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		sendPlain(0, "Hi!");

		expectCmd(1, LOAD_SGR, 1, 0, 0, P1);         // first digit after CSI
		expectCmd(1, EMIT_SGR, 12, 0, 12, P1 | PS);
		expectCmd(1, CUP, 12, 34, 0, P1 | P2);
		sendText(1, "\033[12;34H");
		expectCmd(1, LOAD_SGR, 5, 0, 0, P1);
		expectCmd(1, CUU, 5, 0, 0, P1);
		sendText(1, "\033[5A");
		expectCmd(1, SETMODE, 25, 0, 0, P1);
		sendText(1, "\033[?25h");

		// defaults and single-letter commands
		expectCmd(2, CUP, 1, 1, 0, P1 | P2);
		expectCmd(2, DECSTBM, 1, `CONSOLE_LINES, 0, P1 | P2);
		expectCmd(2, EL, 0, 0, 0, P1);
		expectCmd(2, ED, 0, 0, 0, P1);
		expectCmd(2, IND, 0, 0, 0, 3'b000);
		expectCmd(2, SCS0, 8'h42, 0, 0, P1);
		sendText(2, "\033[H\033[r\033[K\033[J\033D\033(B");

		runInterleaved();
		drain();

		// command port held, so the lanes fill and lane 3 must wait
		start     = cycles;
		holdUntil = cycles + 200;
		sendPlain(0, "p");
		sendPlain(1, "q");
		sendPlain(2, "r");
		sendPlain(3, "st");
		assert (cycles - start >= 200)
			else abortRun("inAck did not stall while outAck was withheld");
		drain();

		repeat (20) @(posedge clk);
		if (uut.protocolChecks.failCount == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
			abortRun("a handshake assertion failed near the end of the run");
	end

endmodule

// ==== vtMux.f ====
+incdir+logic
logic/vtPkg.sv
logic/byteRouter.sv
logic/escParser.sv
logic/commandArbiter.sv
logic/vtMux.sv
sim/vtMux_assert.sv
sim/vtMux_tb.sv
